// File: design/iq_pkg.sv
package iq_pkg;

    // queue geometry
    localparam int IQ_ENTRIES = 4;
    localparam int IQ_SEL     = 2;

    // physical register tag width
    localparam int TAG_W = 5;

    // dispatch request count, legal values 0..2
    localparam int REQ_W = 2;

    // widest request a single cycle may carry
    localparam int REQ_MAX = 2;

    // instruction class carried with each entry
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_MUL    = 3'd1,
        OP_LOAD   = 3'd2,
        OP_STORE  = 3'd3,
        OP_BRANCH = 3'd4
    } iq_op_e;

    // true when a broadcast tag wakes up a source operand
    function automatic logic tag_hit(
        input logic             valid,
        input logic [TAG_W-1:0] bcast_tag,
        input logic [TAG_W-1:0] src_tag
    );
        return valid && (bcast_tag == src_tag);
    endfunction

    // entry index one past the given one, wrapping around the ring
    function automatic logic [IQ_SEL-1:0] next_index(
        input logic [IQ_SEL-1:0] idx
    );
        return IQ_SEL'(idx + 1'b1);
    endfunction

endpackage

// File: design/entry_searcher.sv
`timescale 1ns/1ns

module entry_searcher (
    input  logic [iq_pkg::IQ_ENTRIES-1:0] begin_entry_i,
    input  logic [iq_pkg::IQ_ENTRIES-1:0] end_entry_i,
    output logic [iq_pkg::IQ_SEL-1:0]     begin_select_o,
    output logic                          begin_en_o,
    output logic [iq_pkg::IQ_SEL-1:0]     end_select_o,
    output logic                          end_en_o
);
    import iq_pkg::*;

    // lowest set bit of the begin vector
    always_comb begin
        logic found;
        found          = 1'b0;
        begin_select_o = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (begin_entry_i[i] && !found) begin
                begin_select_o = IQ_SEL'(i);
                found          = 1'b1;
            end
        end
        begin_en_o = found;
    end

    // last bit of the first run of ones in the end vector
    always_comb begin
        logic in_run;
        logic run_done;
        in_run       = 1'b0;
        run_done     = 1'b0;
        end_select_o = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (!run_done) begin
                if (end_entry_i[i]) begin
                    end_select_o = IQ_SEL'(i);
                    in_run       = 1'b1;
                end else if (in_run) begin
                    // first zero after the run closes it
                    run_done = 1'b1;
                end
            end
        end
        end_en_o = in_run;
    end

endmodule

// File: design/inorder_alloc_issue_unit.sv
`timescale 1ns/1ns

module inorder_alloc_issue_unit (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic [iq_pkg::REQ_W-1:0]      req_num_i,
    input  logic [iq_pkg::IQ_ENTRIES-1:0] busy_vector_i,
    input  logic [iq_pkg::IQ_ENTRIES-1:0] ready_vector_i,
    input  logic                          dispatch_stall_i,
    input  logic                          kill_i,
    output logic [iq_pkg::IQ_SEL-1:0]     alloc_ptr_o,
    output logic                          dispatch_ready_o,
    output logic                          dispatch_fire_o,
    output logic [iq_pkg::IQ_SEL-1:0]     issue_ptr_o,
    output logic                          issue_valid_o
);
    import iq_pkg::*;

    logic [IQ_SEL-1:0] end_free;
    logic              not_full;
    logic [IQ_SEL-1:0] begin_busy;
    logic              wrapped;

    // free entries form one circular run starting at the alloc pointer
    entry_searcher searcher_free (
        .begin_entry_i  (~busy_vector_i),
        .end_entry_i    (~busy_vector_i),
        .begin_select_o (),
        .begin_en_o     (not_full),
        .end_select_o   (end_free),
        .end_en_o       ()
    );

    entry_searcher searcher_busy (
        .begin_entry_i  (busy_vector_i),
        .end_entry_i    (busy_vector_i),
        .begin_select_o (begin_busy),
        .begin_en_o     (),
        .end_select_o   (),
        .end_en_o       ()
    );

    // busy run crosses the top of the ring
    assign wrapped = (begin_busy == '0) && busy_vector_i[IQ_ENTRIES-1];

    always_comb begin
        if (!not_full) begin
            // full ring, oldest sits where the next write would go
            issue_ptr_o = alloc_ptr_o;
        end else if (wrapped) begin
            issue_ptr_o = next_index(end_free);
        end else begin
            issue_ptr_o = begin_busy;
        end
    end

    assign issue_valid_o = ready_vector_i[issue_ptr_o];

    always_comb begin
        case (req_num_i)
            REQ_W'(0): dispatch_ready_o = 1'b1;
            REQ_W'(1): dispatch_ready_o = !busy_vector_i[alloc_ptr_o];
            default:   dispatch_ready_o = !busy_vector_i[alloc_ptr_o]
                                       && !busy_vector_i[next_index(alloc_ptr_o)];
        endcase
    end

    assign dispatch_fire_o = (req_num_i != '0) && dispatch_ready_o
                          && !dispatch_stall_i && !kill_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alloc_ptr_o <= '0;
        end else if (dispatch_fire_o) begin
            alloc_ptr_o <= IQ_SEL'(alloc_ptr_o + req_num_i);
        end
    end

    a_req_num_legal: assert property (@(posedge clk_i) disable iff (reset_i)
        req_num_i <= REQ_W'(REQ_MAX))
        else $error("dispatch request count above %0d", REQ_MAX);

    // the selected entry must really hold an instruction
    a_issue_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        issue_valid_o |-> busy_vector_i[issue_ptr_o])
        else $error("issue valid on an empty entry");

endmodule

// File: design/iq_entry_array.sv
`timescale 1ns/1ns

module iq_entry_array (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic [iq_pkg::IQ_SEL-1:0]     alloc_ptr_i,
    input  logic                          dispatch_fire_i,
    input  logic [iq_pkg::REQ_W-1:0]      req_num_i,
    input  iq_pkg::iq_op_e                slot0_op_i,
    input  logic [iq_pkg::TAG_W-1:0]      slot0_dest_tag_i,
    input  logic [iq_pkg::TAG_W-1:0]      slot0_src0_tag_i,
    input  logic [iq_pkg::TAG_W-1:0]      slot0_src1_tag_i,
    input  logic                          slot0_src0_rdy_i,
    input  logic                          slot0_src1_rdy_i,
    input  iq_pkg::iq_op_e                slot1_op_i,
    input  logic [iq_pkg::TAG_W-1:0]      slot1_dest_tag_i,
    input  logic [iq_pkg::TAG_W-1:0]      slot1_src0_tag_i,
    input  logic [iq_pkg::TAG_W-1:0]      slot1_src1_tag_i,
    input  logic                          slot1_src0_rdy_i,
    input  logic                          slot1_src1_rdy_i,
    input  logic                          wakeup_valid_i,
    input  logic [iq_pkg::TAG_W-1:0]      wakeup_tag_i,
    input  logic                          kill_i,
    input  logic [iq_pkg::IQ_SEL-1:0]     issue_ptr_i,
    input  logic                          issue_fire_i,
    output logic [iq_pkg::IQ_ENTRIES-1:0] busy_vector_o,
    output logic [iq_pkg::IQ_ENTRIES-1:0] ready_vector_o,
    output iq_pkg::iq_op_e                issue_op_o,
    output logic [iq_pkg::TAG_W-1:0]      issue_dest_tag_o
);
    import iq_pkg::*;

    logic [IQ_ENTRIES-1:0] busy_q;
    iq_op_e                op_q       [IQ_ENTRIES];
    logic [TAG_W-1:0]      dest_tag_q [IQ_ENTRIES];
    logic [TAG_W-1:0]      src0_tag_q [IQ_ENTRIES];
    logic [TAG_W-1:0]      src1_tag_q [IQ_ENTRIES];
    logic [IQ_ENTRIES-1:0] src0_rdy_q;
    logic [IQ_ENTRIES-1:0] src1_rdy_q;

    logic [IQ_ENTRIES-1:0] wr0_en;
    logic [IQ_ENTRIES-1:0] wr1_en;
    logic [IQ_SEL-1:0]     slot1_ptr;

    // incoming operands also see this cycle's broadcast
    logic slot0_src0_rdy;
    logic slot0_src1_rdy;
    logic slot1_src0_rdy;
    logic slot1_src1_rdy;

    assign slot1_ptr = next_index(alloc_ptr_i);

    assign slot0_src0_rdy = slot0_src0_rdy_i || tag_hit(wakeup_valid_i, wakeup_tag_i,
                                                         slot0_src0_tag_i);
    assign slot0_src1_rdy = slot0_src1_rdy_i || tag_hit(wakeup_valid_i, wakeup_tag_i,
                                                         slot0_src1_tag_i);
    assign slot1_src0_rdy = slot1_src0_rdy_i || tag_hit(wakeup_valid_i, wakeup_tag_i,
                                                         slot1_src0_tag_i);
    assign slot1_src1_rdy = slot1_src1_rdy_i || tag_hit(wakeup_valid_i, wakeup_tag_i,
                                                         slot1_src1_tag_i);

    always_comb begin
        for (int e = 0; e < IQ_ENTRIES; e++) begin
            wr0_en[e] = dispatch_fire_i && (alloc_ptr_i == IQ_SEL'(e));
            // second slot only on a two-wide dispatch
            wr1_en[e] = dispatch_fire_i && (req_num_i == REQ_W'(REQ_MAX))
                     && (slot1_ptr == IQ_SEL'(e));
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else if (kill_i) begin
            busy_q <= '0;
        end else begin
            for (int e = 0; e < IQ_ENTRIES; e++) begin
                if (wr0_en[e] || wr1_en[e]) begin
                    busy_q[e] <= 1'b1;
                end else if (issue_fire_i && (issue_ptr_i == IQ_SEL'(e))) begin
                    busy_q[e] <= 1'b0;
                end
            end
        end
    end

    // payload and operand state
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < IQ_ENTRIES; e++) begin
            if (wr0_en[e]) begin
                op_q[e]       <= slot0_op_i;
                dest_tag_q[e] <= slot0_dest_tag_i;
                src0_tag_q[e] <= slot0_src0_tag_i;
                src1_tag_q[e] <= slot0_src1_tag_i;
                src0_rdy_q[e] <= slot0_src0_rdy;
                src1_rdy_q[e] <= slot0_src1_rdy;
            end else if (wr1_en[e]) begin
                op_q[e]       <= slot1_op_i;
                dest_tag_q[e] <= slot1_dest_tag_i;
                src0_tag_q[e] <= slot1_src0_tag_i;
                src1_tag_q[e] <= slot1_src1_tag_i;
                src0_rdy_q[e] <= slot1_src0_rdy;
                src1_rdy_q[e] <= slot1_src1_rdy;
            end else if (busy_q[e]) begin
                if (tag_hit(wakeup_valid_i, wakeup_tag_i, src0_tag_q[e])) begin
                    src0_rdy_q[e] <= 1'b1;
                end
                if (tag_hit(wakeup_valid_i, wakeup_tag_i, src1_tag_q[e])) begin
                    src1_rdy_q[e] <= 1'b1;
                end
            end
        end
    end

    assign busy_vector_o  = busy_q;
    assign ready_vector_o = busy_q & src0_rdy_q & src1_rdy_q;

    assign issue_op_o       = op_q[issue_ptr_i];
    assign issue_dest_tag_o = dest_tag_q[issue_ptr_i];

    // pointer unit must only hand out free entries
    a_no_overwrite: assert property (@(posedge clk_i) disable iff (reset_i)
        dispatch_fire_i |-> ((wr0_en | wr1_en) & busy_q) == '0)
        else $error("dispatch wrote a busy entry");

endmodule

// File: design/inorder_issue_queue.sv
`timescale 1ns/1ns

module inorder_issue_queue (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic [iq_pkg::REQ_W-1:0] req_num_i,
    input  logic                     dispatch_stall_i,
    input  logic                     kill_i,
    input  iq_pkg::iq_op_e           slot0_op_i,
    input  logic [iq_pkg::TAG_W-1:0] slot0_dest_tag_i,
    input  logic [iq_pkg::TAG_W-1:0] slot0_src0_tag_i,
    input  logic [iq_pkg::TAG_W-1:0] slot0_src1_tag_i,
    input  logic                     slot0_src0_rdy_i,
    input  logic                     slot0_src1_rdy_i,
    input  iq_pkg::iq_op_e           slot1_op_i,
    input  logic [iq_pkg::TAG_W-1:0] slot1_dest_tag_i,
    input  logic [iq_pkg::TAG_W-1:0] slot1_src0_tag_i,
    input  logic [iq_pkg::TAG_W-1:0] slot1_src1_tag_i,
    input  logic                     slot1_src0_rdy_i,
    input  logic                     slot1_src1_rdy_i,
    output logic                     dispatch_ready_o,
    input  logic                     wakeup_valid_i,
    input  logic [iq_pkg::TAG_W-1:0] wakeup_tag_i,
    input  logic                     issue_grant_i,
    output logic                     issue_valid_o,
    output iq_pkg::iq_op_e           issue_op_o,
    output logic [iq_pkg::TAG_W-1:0] issue_dest_tag_o
);
    import iq_pkg::*;

    logic [IQ_SEL-1:0]     alloc_ptr;
    logic                  dispatch_fire;
    logic [IQ_SEL-1:0]     issue_ptr;
    logic [IQ_ENTRIES-1:0] busy_vector;
    logic [IQ_ENTRIES-1:0] ready_vector;
    logic                  issue_fire;

    // oldest entry leaves once the consumer takes it
    assign issue_fire = issue_valid_o && issue_grant_i;

    inorder_alloc_issue_unit u_alloc_issue (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .req_num_i        (req_num_i),
        .busy_vector_i    (busy_vector),
        .ready_vector_i   (ready_vector),
        .dispatch_stall_i (dispatch_stall_i),
        .kill_i           (kill_i),
        .alloc_ptr_o      (alloc_ptr),
        .dispatch_ready_o (dispatch_ready_o),
        .dispatch_fire_o  (dispatch_fire),
        .issue_ptr_o      (issue_ptr),
        .issue_valid_o    (issue_valid_o)
    );

    iq_entry_array u_entries (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .alloc_ptr_i      (alloc_ptr),
        .dispatch_fire_i  (dispatch_fire),
        .req_num_i        (req_num_i),
        .slot0_op_i       (slot0_op_i),
        .slot0_dest_tag_i (slot0_dest_tag_i),
        .slot0_src0_tag_i (slot0_src0_tag_i),
        .slot0_src1_tag_i (slot0_src1_tag_i),
        .slot0_src0_rdy_i (slot0_src0_rdy_i),
        .slot0_src1_rdy_i (slot0_src1_rdy_i),
        .slot1_op_i       (slot1_op_i),
        .slot1_dest_tag_i (slot1_dest_tag_i),
        .slot1_src0_tag_i (slot1_src0_tag_i),
        .slot1_src1_tag_i (slot1_src1_tag_i),
        .slot1_src0_rdy_i (slot1_src0_rdy_i),
        .slot1_src1_rdy_i (slot1_src1_rdy_i),
        .wakeup_valid_i   (wakeup_valid_i),
        .wakeup_tag_i     (wakeup_tag_i),
        .kill_i           (kill_i),
        .issue_ptr_i      (issue_ptr),
        .issue_fire_i     (issue_fire),
        .busy_vector_o    (busy_vector),
        .ready_vector_o   (ready_vector),
        .issue_op_o       (issue_op_o),
        .issue_dest_tag_o (issue_dest_tag_o)
    );

endmodule

// File: tests/iq_stimulus_table.svh
// each row holds req, stall, kill, slot 0, slot 1, wakeup valid, wakeup tag and grant
// then the expected dispatch_ready_o, issue_valid_o, issue_op_o and issue_dest_tag_o

// in-order issue with singles, pairs and pointer wrap
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 0, 1, 0, OP_ALU, 0);
add_row(1, 0, 0, insn(OP_ALU, 1), NO_SLOT, 0, 0, 0, 1, 0, OP_ALU, 0);
add_row(2, 0, 0, insn(OP_MUL, 2), insn(OP_LOAD, 3), 0, 0, 1, 1, 1, OP_ALU, 1);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_MUL, 2);
add_row(2, 0, 0, insn(OP_STORE, 4), insn(OP_BRANCH, 5), 0, 0, 1, 1, 1, OP_LOAD, 3);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_STORE, 4);
add_row(1, 0, 0, insn(OP_ALU, 6), NO_SLOT, 0, 0, 1, 1, 1, OP_BRANCH, 5);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_ALU, 6);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 0, OP_ALU, 0);

// oldest entry waits on tag 10 while the younger one is ready
add_row(2, 0, 0, insn_wait(OP_LOAD, 7, 10), insn(OP_ALU, 8), 0, 0, 1, 1, 0, OP_ALU, 0);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 0, OP_ALU, 0);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 1, 10, 1, 1, 0, OP_ALU, 0);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_LOAD, 7);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_ALU, 8);

// fill to three then four entries with an incoming slot woken in flight
add_row(2, 0, 0, insn_wait(OP_MUL, 9, 11), insn(OP_ALU, 10), 1, 11, 0, 1, 0, OP_ALU, 0);
add_row(1, 0, 0, insn(OP_STORE, 11), NO_SLOT, 0, 0, 0, 1, 1, OP_MUL, 9);
add_row(2, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 0, 0, 1, OP_MUL, 9);
add_row(1, 0, 0, insn(OP_BRANCH, 12), NO_SLOT, 0, 0, 0, 1, 1, OP_MUL, 9);
add_row(1, 0, 0, insn(OP_LOAD, 30), NO_SLOT, 0, 0, 0, 0, 1, OP_MUL, 9);
add_row(2, 0, 0, insn(OP_LOAD, 30), insn(OP_LOAD, 31), 0, 0, 0, 0, 1, OP_MUL, 9);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 0, 1, 1, OP_MUL, 9);

// back-pressure holds the oldest entry until a grant
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_MUL, 9);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 0, 1, 1, OP_ALU, 10);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 0, 1, 1, OP_ALU, 10);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_ALU, 10);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_STORE, 11);
add_row(2, 0, 0, insn(OP_ALU, 13), insn(OP_MUL, 14), 0, 0, 1, 1, 1, OP_BRANCH, 12);

// kill with a dispatch pending then refill from the held pointer
add_row(1, 0, 1, insn(OP_LOAD, 15), NO_SLOT, 0, 0, 1, 1, 1, OP_ALU, 13);
add_row(2, 0, 0, insn(OP_STORE, 16), insn(OP_ALU, 20), 0, 0, 1, 1, 0, OP_ALU, 0);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_STORE, 16);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_ALU, 20);

// stalled request leaves no entry behind
add_row(2, 1, 0, insn(OP_MUL, 17), insn(OP_LOAD, 18), 0, 0, 1, 1, 0, OP_ALU, 0);
add_row(1, 0, 0, insn(OP_BRANCH, 19), NO_SLOT, 0, 0, 1, 1, 0, OP_ALU, 0);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 1, OP_BRANCH, 19);
add_row(0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 1, 1, 0, OP_ALU, 0);

// File: tests/tb_inorder_issue_queue.sv
`timescale 1ns/1ns

module tb_inorder_issue_queue;
    import iq_pkg::*;

    localparam int HALF_PERIOD  = 50;
    localparam int DRIVE_DELAY  = 5;
    localparam int SAMPLE_DELAY = 90;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_TIMEOUT = 10;

    // one dispatch slot as the table writes it
    typedef struct packed {
        iq_op_e op;
        int     dest;
        int     src0;
        int     src1;
        int     rdy0;
        int     rdy1;
    } slot_t;

    // one cycle of stimulus and the outputs expected before the next edge
    typedef struct packed {
        int     req;
        int     stall;
        int     kill;
        slot_t  s0;
        slot_t  s1;
        int     wk_valid;
        int     wk_tag;
        int     grant;
        int     exp_ready;
        int     exp_valid;
        iq_op_e exp_op;
        int     exp_dest;
    } row_t;

    localparam slot_t NO_SLOT = '{OP_ALU, 0, 0, 0, 1, 1};

    logic             clk_i;
    logic             reset_i;
    logic [REQ_W-1:0] req_num_i;
    logic             dispatch_stall_i;
    logic             kill_i;
    iq_op_e           slot0_op_i;
    logic [TAG_W-1:0] slot0_dest_tag_i;
    logic [TAG_W-1:0] slot0_src0_tag_i;
    logic [TAG_W-1:0] slot0_src1_tag_i;
    logic             slot0_src0_rdy_i;
    logic             slot0_src1_rdy_i;
    iq_op_e           slot1_op_i;
    logic [TAG_W-1:0] slot1_dest_tag_i;
    logic [TAG_W-1:0] slot1_src0_tag_i;
    logic [TAG_W-1:0] slot1_src1_tag_i;
    logic             slot1_src0_rdy_i;
    logic             slot1_src1_rdy_i;
    logic             dispatch_ready_o;
    logic             wakeup_valid_i;
    logic [TAG_W-1:0] wakeup_tag_i;
    logic             issue_grant_i;
    logic             issue_valid_o;
    iq_op_e           issue_op_o;
    logic [TAG_W-1:0] issue_dest_tag_o;

    row_t table_q[$];
    int   error_count;
    int   timeout_count;

    inorder_issue_queue u_inorder_issue_queue (.*);

    always #HALF_PERIOD clk_i = ~clk_i;

    // fully ready instruction with zero source tags
    function automatic slot_t insn(input iq_op_e op, input int dest);
        slot_t s;
        s = '{op, dest, 0, 0, 1, 1};
        return s;
    endfunction

    // source 0 waits for the given tag
    function automatic slot_t insn_wait(input iq_op_e op, input int dest, input int tag);
        slot_t s;
        s = '{op, dest, tag, 0, 0, 1};
        return s;
    endfunction

    function automatic void add_row(
        input int req, input int stall, input int kill, input slot_t s0, input slot_t s1,
        input int wk_valid, input int wk_tag, input int grant,
        input int exp_ready, input int exp_valid, input iq_op_e exp_op, input int exp_dest
    );
        row_t r;
        r = '{req, stall, kill, s0, s1, wk_valid, wk_tag, grant,
              exp_ready, exp_valid, exp_op, exp_dest};
        table_q.push_back(r);
    endfunction

    function automatic void apply_row(input row_t r);
        req_num_i        = REQ_W'(r.req);
        dispatch_stall_i = (r.stall != 0);
        kill_i           = (r.kill != 0);
        slot0_op_i       = r.s0.op;
        slot0_dest_tag_i = TAG_W'(r.s0.dest);
        slot0_src0_tag_i = TAG_W'(r.s0.src0);
        slot0_src1_tag_i = TAG_W'(r.s0.src1);
        slot0_src0_rdy_i = (r.s0.rdy0 != 0);
        slot0_src1_rdy_i = (r.s0.rdy1 != 0);
        slot1_op_i       = r.s1.op;
        slot1_dest_tag_i = TAG_W'(r.s1.dest);
        slot1_src0_tag_i = TAG_W'(r.s1.src0);
        slot1_src1_tag_i = TAG_W'(r.s1.src1);
        slot1_src0_rdy_i = (r.s1.rdy0 != 0);
        slot1_src1_rdy_i = (r.s1.rdy1 != 0);
        wakeup_valid_i   = (r.wk_valid != 0);
        wakeup_tag_i     = TAG_W'(r.wk_tag);
        issue_grant_i    = (r.grant != 0);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    // queue should accept dispatch and show no issue once out of reset
    task automatic wait_idle();
        int   cycles;
        logic idle;
        cycles = 0;
        idle   = (dispatch_ready_o === 1'b1) && (issue_valid_o === 1'b0);
        while (!idle && cycles < IDLE_TIMEOUT) begin
            @(posedge clk_i);
            #(DRIVE_DELAY);
            cycles++;
            idle = (dispatch_ready_o === 1'b1) && (issue_valid_o === 1'b0);
        end
        if (!idle) begin
            $display("timeout: queue not idle %0d cycles after reset", IDLE_TIMEOUT);
            timeout_count++;
        end
    endtask

    initial begin
        row_t idle_row;
        error_count   = 0;
        timeout_count = 0;
        clk_i         = 1'b0;
        reset_i       = 1'b1;
        idle_row      = '{0, 0, 0, NO_SLOT, NO_SLOT, 0, 0, 0, 0, 0, OP_ALU, 0};
        apply_row(idle_row);
        `include "iq_stimulus_table.svh"

        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        reset_i = 1'b0;
        wait_idle();

        if (timeout_count == 0) begin
            for (int i = 0; i < table_q.size(); i++) begin
                apply_row(table_q[i]);
                #(SAMPLE_DELAY);
                check_value(32'(dispatch_ready_o), table_q[i].exp_ready,
                            $sformatf("row %0d dispatch_ready_o", i));
                check_value(32'(issue_valid_o), table_q[i].exp_valid,
                            $sformatf("row %0d issue_valid_o", i));
                // payload only means something while valid
                if (table_q[i].exp_valid != 0) begin
                    check_value(32'(issue_op_o), 32'(table_q[i].exp_op),
                                $sformatf("row %0d issue_op_o", i));
                    check_value(32'(issue_dest_tag_o), table_q[i].exp_dest,
                                $sformatf("row %0d issue_dest_tag_o", i));
                end
                @(posedge clk_i);
                #(DRIVE_DELAY);
            end
        end

        $display("rows %0d, mismatches %0d, timeouts %0d",
                 table_q.size(), error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tests
design/iq_pkg.sv
design/entry_searcher.sv
design/inorder_alloc_issue_unit.sv
design/iq_entry_array.sv
design/inorder_issue_queue.sv
tests/tb_inorder_issue_queue.sv

// File: Bender.yml
package:
  name: inorder_issue_queue

sources:
  - design/iq_pkg.sv
  - design/entry_searcher.sv
  - design/inorder_alloc_issue_unit.sv
  - design/iq_entry_array.sv
  - design/inorder_issue_queue.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_inorder_issue_queue.sv
